/* build.f */
lcd_pkg.sv
cfg_pkg.sv
pm_video_regs.sv
frame_ring.sv
video_timing.sv
pixel_shader.sv
pm_video_top.sv
tb_clock.sv
pm_video_chk.sv
tb_pm_video.sv

/* run_sim.sh */
#!/bin/sh
# build and run the video path testbench with verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f build.f --top-module tb_pm_video -o vsim \
    || { echo "build failed"; exit 1; }
./obj_dir/vsim > sim.log 2>&1
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation did not complete"; exit 1; }
exit 0

/* tb_pm_video.sv */
//////////////////////////////////////////////////
// video path testbench
// lcd source model, bus master and pixel reference
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_pm_video;

    localparam int FRAME_PIX      = lcd_pkg::LCD_XSIZE * lcd_pkg::LCD_YSIZE;
    localparam int RASTER_PIX     = lcd_pkg::H_TOTAL * lcd_pkg::V_TOTAL;
    localparam int TIMEOUT_CYCLES = 5_000_000;  // about nine raster frames plus margin

    logic        clk_sys;
    logic        reset;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [1:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        lcd_frame_done;
    logic [7:0]  lcd_column;
    logic [5:0]  lcd_contrast;
    logic [6:0]  lcd_read_x;
    logic [2:0]  lcd_read_y;
    logic [7:0]  video_r;
    logic [7:0]  video_g;
    logic [7:0]  video_b;
    logic        video_hs;
    logic        video_vs;
    logic        video_de;

    // lcd frame tables, one slot per ring buffer
    logic [7:0]  lcd_tab [lcd_pkg::FB_COUNT][lcd_pkg::FB_DEPTH];
    logic [5:0]  tab_con [lcd_pkg::FB_COUNT];
    int          cur_slot;   // follows the write index
    int          new_slot;   // last completed capture
    logic [23:0] exp_off;
    logic [23:0] exp_on;
    logic [31:0] rng;
    int          errors;
    int          cycles = 0;

    tb_clock u_tb_clock (.clk_sys(clk_sys), .reset(reset));

    pm_video_top u_pm_video_top (.*);

    // lcd source answers the read address directly
    always_comb
        lcd_column = lcd_tab[cur_slot][int'(lcd_read_y) * lcd_pkg::LCD_XSIZE + int'(lcd_read_x)];

    always @(posedge clk_sys)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("timeout after %0d cycles, the tests did not finish", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] shade_channel(input int lvl, input logic [7:0] c_off,
                                                 input logic [7:0] c_on);
        int acc;
        acc = (255 - lvl) * int'(c_off) + lvl * int'(c_on);
        return 8'(acc / 255);
    endfunction

    //////////////////////////////////////////////////
    // reference pixel from the frame tables
    //////////////////////////////////////////////////
    function automatic logic [23:0] expected_pixel(input int x, input int y, input logic blend);
        int         lvl;
        int         sum;
        int         addr;
        int         slot;
        logic [6:0] idx;
        lvl  = 0;
        sum  = 0;
        addr = (y / 8) * lcd_pkg::LCD_XSIZE + x;
        for (int k = 0; k < lcd_pkg::FB_COUNT; k++)
        begin
            slot = (new_slot - k + lcd_pkg::FB_COUNT) % lcd_pkg::FB_COUNT;
            idx  = {tab_con[slot], lcd_tab[slot][addr][y % 8]};
            if (k == 0)
                lvl = int'(lcd_pkg::CONTRAST_MAP[idx]);  // newest frame
            sum = sum + int'(lcd_pkg::CONTRAST_MAP[idx]);
        end
        if (blend)
            lvl = sum / 4;
        return {shade_channel(lvl, exp_off[23:16], exp_on[23:16]),
                shade_channel(lvl, exp_off[15:8], exp_on[15:8]),
                shade_channel(lvl, exp_off[7:0], exp_on[7:0])};
    endfunction

    task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge clk_sys);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        do
        begin
            @(negedge clk_sys);
            wait_cnt++;
        end
        while (!wb_ack && wait_cnt < 16);
        assert (wb_ack)
        else
        begin
            errors++;
            $display("bus access to address %0d never got an ack", adr);
        end
        rdata = wb_dat_r;
        @(posedge clk_sys);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic check_read(input string name, input logic [1:0] adr, input logic [31:0] want);
        logic [31:0] got;
        bus_access(1'b0, adr, 32'd0, got);
        assert (got == want)
        else
        begin
            errors++;
            $display("FAIL %s: expected %08h, got %08h", name, want, got);
        end
    endtask

    task automatic set_colors(input logic [23:0] c_off, input logic [23:0] c_on);
        logic [31:0] unused;
        bus_access(1'b1, cfg_pkg::REG_OFF_COLOR, {8'h00, c_off}, unused);
        bus_access(1'b1, cfg_pkg::REG_ON_COLOR, {8'h00, c_on}, unused);
        exp_off = c_off;
        exp_on  = c_on;
    endtask

    // one sample per raster pixel, outputs are stable here
    task automatic next_pixel();
        do
            @(negedge clk_sys);
        while (!u_pm_video_top.pix_ce);
    endtask

    task automatic wait_frame_start();
        logic vs_q;
        vs_q = 1'b1;
        while (!(video_vs && !vs_q))
        begin
            vs_q = video_vs;
            next_pixel();
        end
    endtask

    // fill the next slot, pulse frame done, wait for the address wrap
    task automatic capture_frame(input logic [5:0] contrast);
        for (int a = 0; a < lcd_pkg::FB_DEPTH; a++)
        begin
            rng = xorshift(rng);
            lcd_tab[cur_slot][a] = rng[7:0];
        end
        tab_con[cur_slot] = contrast;
        @(posedge clk_sys);
        #1;
        lcd_contrast   = contrast;
        lcd_frame_done = 1'b1;
        @(posedge clk_sys);
        #1;
        lcd_frame_done = 1'b0;
        do
            @(negedge clk_sys);
        while (!(lcd_read_x == 7'd95 && lcd_read_y == 3'd7));
        do
            @(negedge clk_sys);
        while (lcd_read_x != 7'd0 || lcd_read_y != 3'd0);
        new_slot = cur_slot;
        cur_slot = (cur_slot + 1) % lcd_pkg::FB_COUNT;
    endtask

    // compares every image pixel of the next frame
    task automatic check_frame(input string name, input logic blend, input logic off_check);
        int          n;
        int          x;
        int          y;
        logic [23:0] got;
        logic [23:0] want;
        wait_frame_start();
        n = 0;
        while (n < FRAME_PIX)
        begin
            next_pixel();
            if (video_de)
            begin
                x    = n % lcd_pkg::LCD_XSIZE;
                y    = n / lcd_pkg::LCD_XSIZE;
                got  = {video_r, video_g, video_b};
                want = expected_pixel(x, y, blend);
                assert (got == want)
                else
                begin
                    errors++;
                    $display("FAIL %s (%0d,%0d): expected %06h, got %06h", name, x, y, want, got);
                end
                if (off_check && !lcd_tab[new_slot][(y / 8) * lcd_pkg::LCD_XSIZE + x][y % 8])
                begin
                    assert (got == exp_off)
                    else
                    begin
                        errors++;
                        $display("FAIL %s off (%0d,%0d): expected %06h, got %06h",
                                 name, x, y, exp_off, got);
                    end
                end
                n++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////
    task automatic test_registers();
        logic [31:0] unused;
        check_read("reset ctrl", cfg_pkg::REG_CTRL, 32'h0000_0000);
        check_read("reset off colour", cfg_pkg::REG_OFF_COLOR, 32'h00B7_CAB7);
        check_read("reset on colour", cfg_pkg::REG_ON_COLOR, 32'h0004_1604);
        check_read("reset addr 3", 2'd3, 32'h0000_0000);
        bus_access(1'b1, cfg_pkg::REG_CTRL, 32'hFFFF_FFFF, unused);
        check_read("ctrl readback", cfg_pkg::REG_CTRL, 32'h0000_0001);
        bus_access(1'b1, cfg_pkg::REG_OFF_COLOR, 32'hA512_3456, unused);
        check_read("off colour readback", cfg_pkg::REG_OFF_COLOR, 32'h0012_3456);
        bus_access(1'b1, cfg_pkg::REG_ON_COLOR, 32'h5AAB_CDEF, unused);
        check_read("on colour readback", cfg_pkg::REG_ON_COLOR, 32'h00AB_CDEF);
        bus_access(1'b1, 2'd3, 32'hFFFF_FFFF, unused);
        check_read("addr 3 after write", 2'd3, 32'h0000_0000);
        bus_access(1'b1, cfg_pkg::REG_CTRL, 32'h0000_0000, unused);
        set_colors(24'hB7CAB7, 24'h041604);  // back to defaults
    endtask

    task automatic test_raster();
        int   hs_cnt;
        int   vs_cnt;
        int   vs_len;
        int   de_runs;
        int   run_len;
        logic hs_q;
        logic vs_q;
        logic de_q;
        hs_cnt  = 0;
        vs_cnt  = 0;
        vs_len  = 0;
        de_runs = 0;
        run_len = 0;
        hs_q    = 1'b0;
        vs_q    = 1'b0;
        de_q    = 1'b0;
        wait_frame_start();
        for (int n = 0; n < RASTER_PIX; n++)
        begin
            if (n > 0)
                next_pixel();
            if (video_hs && !hs_q)
                hs_cnt++;
            if (video_vs && !vs_q)
                vs_cnt++;
            if (video_vs)
                vs_len++;
            if (video_de && !de_q)
            begin
                de_runs++;
                run_len = 0;
            end
            if (video_de)
                run_len++;
            if (!video_de && de_q)
            begin
                assert (run_len == lcd_pkg::LCD_XSIZE)
                else
                begin
                    errors++;
                    $display("FAIL de run length: expected %0d, got %0d",
                             lcd_pkg::LCD_XSIZE, run_len);
                end
            end
            hs_q = video_hs;
            vs_q = video_vs;
            de_q = video_de;
        end
        assert (hs_cnt == lcd_pkg::V_TOTAL)
        else
        begin
            errors++;
            $display("FAIL hs pulses: expected %0d, got %0d", lcd_pkg::V_TOTAL, hs_cnt);
        end
        assert (vs_cnt == 1)
        else
        begin
            errors++;
            $display("FAIL vs pulses: expected 1, got %0d", vs_cnt);
        end
        assert (vs_len == 3 * lcd_pkg::H_TOTAL)
        else
        begin
            errors++;
            $display("FAIL vs length: expected %0d, got %0d", 3 * lcd_pkg::H_TOTAL, vs_len);
        end
        assert (de_runs == lcd_pkg::LCD_YSIZE)
        else
        begin
            errors++;
            $display("FAIL de runs: expected %0d, got %0d", lcd_pkg::LCD_YSIZE, de_runs);
        end
    endtask

    task automatic test_single_frame();
        capture_frame(6'h20);
        capture_frame(6'h24);
        capture_frame(6'h28);
        capture_frame(6'h2C);
        check_frame("single frame", 1'b0, 1'b0);
    endtask

    task automatic test_blend();
        logic [31:0] unused;
        capture_frame(6'h08);
        capture_frame(6'h16);
        capture_frame(6'h2A);
        capture_frame(6'h3E);
        bus_access(1'b1, cfg_pkg::REG_CTRL, 32'h0000_0001, unused);
        check_frame("blend", 1'b1, 1'b0);
        bus_access(1'b1, cfg_pkg::REG_CTRL, 32'h0000_0000, unused);
    endtask

    task automatic test_colors();
        set_colors(24'h203040, 24'hF0E0D0);
        capture_frame(6'h00);  // dark pixels map to intensity 0
        check_frame("colours", 1'b0, 1'b1);
    endtask

    initial
    begin
        errors         = 0;
        rng            = 32'd5;
        cur_slot       = 0;
        new_slot       = 0;
        exp_off        = 24'hB7CAB7;
        exp_on         = 24'h041604;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = 2'd0;
        wb_dat_w       = 32'd0;
        lcd_frame_done = 1'b0;
        lcd_contrast   = 6'd0;
        wait (reset === 1'b0);
        repeat (2) @(posedge clk_sys);
        test_registers();
        test_raster();
        test_single_frame();
        test_blend();
        test_colors();
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* pm_video_chk.sv */
//////////////////////////////////////////////////
// bus and video output checker
// bound into the video path top level
//////////////////////////////////////////////////

`timescale 1ns/1ns

module pm_video_chk
(
    input logic clk_sys,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic video_de,
    input logic video_hs,
    input logic video_vs
);

    ack_with_req: assert property (@(posedge clk_sys) disable iff (reset)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wishbone ack seen without cyc and stb");

    ack_one_cycle: assert property (@(posedge clk_sys) disable iff (reset)
        wb_ack |=> !wb_ack)
        else $error("wishbone ack held for two cycles");

    // image never overlaps the sync pulses
    de_outside_sync: assert property (@(posedge clk_sys) disable iff (reset)
        !(video_de && (video_hs || video_vs)))
        else $error("video de high together with hs or vs");

endmodule

bind pm_video_top pm_video_chk u_pm_video_chk
(
    .clk_sys  (clk_sys),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_ack   (wb_ack),
    .video_de (video_de),
    .video_hs (video_hs),
    .video_vs (video_vs)
);

/* tb_clock.sv */
//////////////////////////////////////////////////
// testbench clock and power-on reset
//////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_clock
(
    output logic clk_sys,
    output logic reset
);

    initial
    begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;  // 10 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (8) @(posedge clk_sys);
        #1;
        reset = 1'b0;
    end

endmodule

/* pm_video_top.sv */
//////////////////////////////////////////////////
// handheld lcd video path, top level
//////////////////////////////////////////////////

`timescale 1ns/1ns

module pm_video_top
(
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    input  logic        lcd_frame_done,
    input  logic [7:0]  lcd_column,
    input  logic [5:0]  lcd_contrast,
    output logic [6:0]  lcd_read_x,
    output logic [2:0]  lcd_read_y,
    output logic [7:0]  video_r,
    output logic [7:0]  video_g,
    output logic [7:0]  video_b,
    output logic        video_hs,
    output logic        video_vs,
    output logic        video_de
);

    // raster
    logic            pix_ce;
    logic [6:0]      img_x;
    logic [5:0]      img_y;
    logic            active;
    logic            hs;
    logic            vs;

    // buffer read data
    logic [3:0][7:0] col_bytes;
    logic [3:0][5:0] col_contrast;

    // shader settings
    logic            blend_en;
    logic [23:0]     off_color;
    logic [23:0]     on_color;

    pm_video_regs u_pm_video_regs (.*);

    frame_ring u_frame_ring (.*);

    video_timing u_video_timing (.*);

    pixel_shader u_pixel_shader (.*);

endmodule

/* pixel_shader.sv */
//////////////////////////////////////////////////
// pixel shader
// contrast lookup, optional four frame blend and
// off/on colour mix into the registered outputs
//////////////////////////////////////////////////

`timescale 1ns/1ns

module pixel_shader
(
    input  logic            clk_sys,
    input  logic            reset,
    input  logic            pix_ce,
    input  logic            active,
    input  logic            hs,
    input  logic            vs,
    input  logic [5:0]      img_y,
    input  logic [3:0][7:0] col_bytes,
    input  logic [3:0][5:0] col_contrast,
    input  logic            blend_en,
    input  logic [23:0]     off_color,
    input  logic [23:0]     on_color,
    output logic [7:0]      video_r,
    output logic [7:0]      video_g,
    output logic [7:0]      video_b,
    output logic            video_hs,
    output logic            video_vs,
    output logic            video_de
);

    logic [3:0][7:0] inten;      // per frame intensity
    logic [9:0]      inten_sum;
    logic [7:0]      level;
    logic [1:0]      ce_d;       // stage enables after pix_ce
    logic [1:0]      act_d;
    logic [1:0]      hs_d;
    logic [1:0]      vs_d;

    // floor(((255 - i) * off + i * on) / 255)
    function automatic logic [7:0] mix(input logic [7:0] i, input logic [7:0] c_off,
                                       input logic [7:0] c_on);
        logic [15:0] acc;
        acc = 16'(8'hFF - i) * 16'(c_off) + 16'(i) * 16'(c_on);
        return 8'(acc / 16'd255);
    endfunction

    assign inten_sum = 10'(inten[0]) + 10'(inten[1]) + 10'(inten[2]) + 10'(inten[3]);

    //////////////////////////////////////////////////
    // stage 1 lookup, stage 2 blend
    //////////////////////////////////////////////////
    always_ff @(posedge clk_sys)
    begin
        if (pix_ce)
        begin
            for (int k = 0; k < 4; k++)
                inten[k] <= lcd_pkg::CONTRAST_MAP[{col_contrast[k], col_bytes[k][img_y[2:0]]}];
        end
        if (ce_d[0])
            level <= blend_en ? inten_sum[9:2] : inten[0];  // floor of the mean
    end

    // stage 3 colour mix, syncs follow the same enables
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            ce_d     <= '0;
            act_d    <= '0;
            hs_d     <= '0;
            vs_d     <= '0;
            video_r  <= '0;
            video_g  <= '0;
            video_b  <= '0;
            video_hs <= 1'b0;
            video_vs <= 1'b0;
            video_de <= 1'b0;
        end
        else
        begin
            ce_d <= {ce_d[0], pix_ce};
            if (pix_ce)
            begin
                act_d[0] <= active;
                hs_d[0]  <= hs;
                vs_d[0]  <= vs;
            end
            if (ce_d[0])
            begin
                act_d[1] <= act_d[0];
                hs_d[1]  <= hs_d[0];
                vs_d[1]  <= vs_d[0];
            end
            if (ce_d[1])
            begin
                video_de <= act_d[1];
                video_hs <= hs_d[1];
                video_vs <= vs_d[1];
                // black outside the image
                video_r  <= act_d[1] ? mix(level, off_color[23:16], on_color[23:16]) : 8'd0;
                video_g  <= act_d[1] ? mix(level, off_color[15:8], on_color[15:8]) : 8'd0;
                video_b  <= act_d[1] ? mix(level, off_color[7:0], on_color[7:0]) : 8'd0;
            end
        end
    end

endmodule

/* video_timing.sv */
//////////////////////////////////////////////////
// video timing
// raster counters, sync and image coordinates
//////////////////////////////////////////////////

`timescale 1ns/1ns

module video_timing
(
    input  logic       clk_sys,
    input  logic       reset,
    output logic       pix_ce,
    output logic [6:0] img_x,
    output logic [5:0] img_y,
    output logic       active,
    output logic       hs,
    output logic       vs
);

    logic [2:0] div_cnt;
    logic [8:0] hpos;
    logic [8:0] vpos;
    logic       h_act;
    logic       v_act;
    logic [8:0] x_off;
    logic [8:0] y_off;

    assign pix_ce = div_cnt == 3'(lcd_pkg::PIX_DIV - 1);

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            hpos    <= '0;
            vpos    <= '0;
        end
        else
        begin
            div_cnt <= pix_ce ? 3'd0 : div_cnt + 3'd1;
            if (pix_ce)
            begin
                if (hpos == 9'(lcd_pkg::H_TOTAL - 1))
                begin
                    hpos <= '0;
                    if (vpos == 9'(lcd_pkg::V_TOTAL - 1))
                        vpos <= '0;
                    else
                        vpos <= vpos + 9'd1;
                end
                else
                    hpos <= hpos + 9'd1;
            end
        end
    end

    //////////////////////////////////////////////////
    // active window, centred image
    //////////////////////////////////////////////////
    assign h_act = (hpos >= 9'(lcd_pkg::H_START)) &&
                   (hpos <  9'(lcd_pkg::H_START + lcd_pkg::LCD_XSIZE));
    assign v_act = (vpos >= 9'(lcd_pkg::V_START)) &&
                   (vpos <  9'(lcd_pkg::V_START + lcd_pkg::LCD_YSIZE));
    assign active = h_act && v_act;

    assign x_off = hpos - 9'(lcd_pkg::H_START);
    assign y_off = vpos - 9'(lcd_pkg::V_START);
    assign img_x = active ? x_off[6:0] : 7'd0;  // keeps buffer reads in range
    assign img_y = active ? y_off[5:0] : 6'd0;

    // sync pulses
    assign hs = (hpos >= 9'(lcd_pkg::HS_START)) && (hpos <= 9'(lcd_pkg::HS_END));
    assign vs = (vpos >= 9'(lcd_pkg::VS_FIRST)) && (vpos <= 9'(lcd_pkg::VS_LAST));

endmodule

/* frame_ring.sv */
//////////////////////////////////////////////////
// frame ring
// captures lcd columns into four frame buffers
// and serves one column byte from each per pixel
//////////////////////////////////////////////////

`timescale 1ns/1ns

module frame_ring
(
    input  logic            clk_sys,
    input  logic            reset,
    input  logic            lcd_frame_done,
    input  logic [7:0]      lcd_column,
    input  logic [5:0]      lcd_contrast,
    input  logic [6:0]      img_x,
    input  logic [5:0]      img_y,
    output logic [6:0]      lcd_read_x,
    output logic [2:0]      lcd_read_y,
    output logic [3:0][7:0] col_bytes,      // newest frame first
    output logic [3:0][5:0] col_contrast
);

    logic       frame_pend;
    logic [2:0] step_cnt;
    logic       step;
    logic       last_x;
    logic       last_y;
    logic [1:0] wr_idx;
    logic [1:0] disp_idx;
    logic [1:0] disp_q;
    logic [9:0] wr_addr;
    logic [9:0] rd_addr;
    logic [7:0] fb_mem [lcd_pkg::FB_COUNT][lcd_pkg::FB_DEPTH];
    logic [5:0] contrast_q [lcd_pkg::FB_COUNT];
    logic [7:0] rd_data [lcd_pkg::FB_COUNT];

    assign step    = step_cnt == 3'(lcd_pkg::COLUMN_STEP - 1);
    assign last_x  = lcd_read_x == 7'(lcd_pkg::LCD_XSIZE - 1);
    assign last_y  = lcd_read_y == 3'(lcd_pkg::LCD_PAGES - 1);
    assign wr_addr = 10'(lcd_read_y) * 10'(lcd_pkg::LCD_XSIZE) + 10'(lcd_read_x);
    assign rd_addr = 10'(img_y[5:3]) * 10'(lcd_pkg::LCD_XSIZE) + 10'(img_x);

    //////////////////////////////////////////////////
    // capture sequencing
    //////////////////////////////////////////////////
    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            frame_pend <= 1'b0;
            step_cnt   <= '0;
            lcd_read_x <= '0;
            lcd_read_y <= '0;
            wr_idx     <= '0;
            disp_idx   <= '0;
            disp_q     <= '0;
        end
        else
        begin
            step_cnt <= step ? 3'd0 : step_cnt + 3'd1;  // free running
            disp_q   <= disp_idx;
            if (lcd_frame_done)
                frame_pend <= 1'b1;
            if (frame_pend && step)
            begin
                if (last_x)
                begin
                    lcd_read_x <= '0;
                    if (last_y)
                    begin
                        // frame complete, show it and move on
                        lcd_read_y <= '0;
                        wr_idx     <= wr_idx + 2'd1;
                        disp_idx   <= wr_idx;
                        frame_pend <= 1'b0;
                    end
                    else
                        lcd_read_y <= lcd_read_y + 3'd1;
                end
                else
                    lcd_read_x <= lcd_read_x + 7'd1;
            end
        end
    end

    // buffers and contrast latches
    always_ff @(posedge clk_sys)
    begin
        if (frame_pend && step)
        begin
            fb_mem[wr_idx][wr_addr] <= lcd_column;
            contrast_q[wr_idx]      <= lcd_contrast;  // last column's code stands
        end
        for (int i = 0; i < lcd_pkg::FB_COUNT; i++)
            rd_data[i] <= fb_mem[i][rd_addr];
    end

    // rotate so the display frame comes out first
    always_comb
    begin
        for (int k = 0; k < lcd_pkg::FB_COUNT; k++)
        begin
            col_bytes[k]    = rd_data[disp_q - 2'(k)];
            col_contrast[k] = contrast_q[disp_q - 2'(k)];
        end
    end

endmodule

/* pm_video_regs.sv */
//////////////////////////////////////////////////
// video register block
// wishbone classic slave with blend and colours
//////////////////////////////////////////////////

`timescale 1ns/1ns

module pm_video_regs
(
    input  logic        clk_sys,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic        blend_en,
    output logic [23:0] off_color,
    output logic [23:0] on_color
);

    cfg_pkg::cfg_word_t wr_word;
    cfg_pkg::cfg_word_t rd_word;
    logic               req;

    assign wr_word = wb_dat_w;
    assign req     = wb_cyc && wb_stb && !wb_ack;  // one ack per request

    // readback, unused bits stay zero
    always_comb
    begin
        rd_word = '0;
        case (wb_adr)
            cfg_pkg::REG_CTRL:      rd_word.ctrl[0]    = blend_en;
            cfg_pkg::REG_OFF_COLOR: rd_word.color[2:0] = off_color;
            cfg_pkg::REG_ON_COLOR:  rd_word.color[2:0] = on_color;
            default:                rd_word            = '0;
        endcase
    end

    always_ff @(posedge clk_sys)
    begin
        if (reset)
        begin
            wb_ack    <= 1'b0;
            blend_en  <= 1'b0;
            off_color <= cfg_pkg::OFF_COLOR_RST;
            on_color  <= cfg_pkg::ON_COLOR_RST;
        end
        else
        begin
            wb_ack <= req;
            if (req && wb_we)
            begin
                case (wb_adr)
                    cfg_pkg::REG_CTRL:      blend_en  <= wr_word.ctrl[0];
                    cfg_pkg::REG_OFF_COLOR: off_color <= wr_word.color[2:0];
                    cfg_pkg::REG_ON_COLOR:  on_color  <= wr_word.color[2:0];
                    default:                ;  // address 3 ignores writes
                endcase
            end
        end
    end

    always_ff @(posedge clk_sys)
    begin
        if (req)
            wb_dat_r <= rd_word;
    end

endmodule

/* cfg_pkg.sv */
//////////////////////////////////////////////////
// video register package
// register map, reset values and the data word
//////////////////////////////////////////////////

package cfg_pkg;

    // word addresses
    localparam logic [1:0] REG_CTRL      = 2'd0;
    localparam logic [1:0] REG_OFF_COLOR = 2'd1;
    localparam logic [1:0] REG_ON_COLOR  = 2'd2;

    // pale lcd background and dark pixel
    localparam logic [23:0] OFF_COLOR_RST = 24'hB7CAB7;
    localparam logic [23:0] ON_COLOR_RST  = 24'h041604;

    // one bus word, two decodings
    typedef union packed {
        logic [31:0]     ctrl;   // bit 0 blend enable
        logic [3:0][7:0] color;  // [2] red, [1] green, [0] blue
    } cfg_word_t;

endpackage

/* lcd_pkg.sv */
//////////////////////////////////////////////////
// lcd panel package
// panel geometry, raster timing and the contrast
// to intensity table of the handheld lcd
//////////////////////////////////////////////////

package lcd_pkg;

    // panel, stored as column bytes of 8 rows each
    localparam int LCD_XSIZE   = 96;
    localparam int LCD_YSIZE   = 64;
    localparam int LCD_PAGES   = 8;
    localparam int FB_DEPTH    = 768;   // LCD_XSIZE * LCD_PAGES
    localparam int FB_COUNT    = 4;     // frames kept in the ring
    localparam int COLUMN_STEP = 8;     // clocks per captured column

    //////////////////////////////////////////////////
    // raster, one pixel every PIX_DIV clocks
    //////////////////////////////////////////////////
    localparam int PIX_DIV  = 5;
    localparam int H_TOTAL  = 407;
    localparam int V_TOTAL  = 262;
    localparam int H_START  = 155;      // (407 - 96) / 2
    localparam int V_START  = 99;       // (262 - 64) / 2
    localparam int HS_START = 383;
    localparam int HS_END   = 406;      // inclusive
    localparam int VS_FIRST = 1;
    localparam int VS_LAST  = 3;

    // indexed by {contrast, pixel bit}, dark pixel first
    localparam logic [7:0] CONTRAST_MAP [128] = '{
        8'd0,   8'd4,   8'd0,   8'd4,   8'd0,   8'd4,   8'd0,   8'd4,    // 00-03
        8'd0,   8'd6,   8'd0,   8'd11,  8'd0,   8'd17,  8'd0,   8'd24,   // 04-07
        8'd0,   8'd31,  8'd0,   8'd40,  8'd0,   8'd48,  8'd0,   8'd57,   // 08-0b
        8'd0,   8'd67,  8'd0,   8'd77,  8'd0,   8'd88,  8'd0,   8'd99,   // 0c-0f
        8'd0,   8'd110, 8'd0,   8'd122, 8'd0,   8'd133, 8'd0,   8'd146,  // 10-13
        8'd0,   8'd158, 8'd0,   8'd171, 8'd0,   8'd184, 8'd0,   8'd198,  // 14-17
        8'd0,   8'd212, 8'd0,   8'd226, 8'd0,   8'd240, 8'd0,   8'd255,  // 18-1b
        8'd2,   8'd255, 8'd5,   8'd255, 8'd10,  8'd255, 8'd15,  8'd255,  // 1c-1f
        8'd21,  8'd255, 8'd27,  8'd255, 8'd34,  8'd255, 8'd41,  8'd255,  // 20-23
        8'd48,  8'd255, 8'd56,  8'd255, 8'd64,  8'd255, 8'd73,  8'd255,  // 24-27
        8'd81,  8'd255, 8'd90,  8'd255, 8'd100, 8'd255, 8'd109, 8'd255,  // 28-2b
        8'd119, 8'd255, 8'd129, 8'd255, 8'd139, 8'd255, 8'd149, 8'd255,  // 2c-2f
        8'd160, 8'd255, 8'd171, 8'd255, 8'd182, 8'd255, 8'd193, 8'd255,  // 30-33
        8'd204, 8'd255, 8'd216, 8'd255, 8'd228, 8'd255, 8'd240, 8'd255,  // 34-37
        8'd240, 8'd255, 8'd240, 8'd255, 8'd240, 8'd255, 8'd240, 8'd255,  // 38-3b
        8'd240, 8'd255, 8'd240, 8'd255, 8'd240, 8'd255, 8'd240, 8'd255   // 3c-3f
    };

endpackage
